/* source/pipe_defs.svh */
// Width and latency macros for the pipeline control block, included by the package and RTL
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Register number width
`define REG_ADDR_W 5

// Instruction address width
`define PC_W 32

// Tuse and Tnew counts
`define T_W 3
`define TUSE_INF 7  // Source never read

// Multiply/divide unit occupancy in cycles
`define MD_MULT_CYCLES 5
`define MD_DIV_CYCLES 10
`define MD_CNT_W 4

`endif

/* source/pipePkg.sv */
// Shared types of the pipeline control block, imported by every RTL module and the testbench
`include "pipe_defs.svh"

package pipePkg;

    typedef logic [`REG_ADDR_W-1:0] regAddr_t;  // GPR number
    typedef logic [`PC_W-1:0] pcVal_t;
    typedef logic [`T_W-1:0] tCycles_t;         // Tuse / Tnew in cycles

    // Decoded opcodes, no real encoding
    typedef enum logic [4:0] {
        NOP, ADDU, SLL, ORI, LUI,
        LW, LB, SW, BEQ, JR,
        JAL, MULT, DIV, MFLO, MTLO,
        MFC0, MTC0, ERET, ILLEGAL
    } instrOp_t;

    // Flush command towards the PC logic
    typedef enum logic [1:0] {
        KC_NONE,
        KC_KTEXT,   // Jump to exception handler
        KC_ERET     // Return to EPC
    } kCtrl_t;

    typedef enum logic {
        KS_USER,
        KS_KERNEL
    } kState_t;

    // One instruction as it moves down the pipe
    typedef struct packed {
        logic valid;
        instrOp_t op;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;    // Written register, 0 if none
        pcVal_t pc;
        logic bd;          // In a branch delay slot
        tCycles_t tnew;    // Cycles until the result is ready
    } stageRec_t;

endpackage

/* source/instrTiming.sv */
// Tuse/Tnew decode of the ID instruction, feeding the stall logic and the EX stage record
`include "pipe_defs.svh"

module instrTiming import pipePkg::*; (
    input  instrOp_t op,
    output tCycles_t tuseRs,
    output tCycles_t tuseRt,
    output tCycles_t tnewId,
    output logic     isMd
);

    localparam tCycles_t TINF = `TUSE_INF;

    always_comb begin
        tuseRs = TINF;      // Unused unless the opcode says so
        tuseRt = TINF;
        tnewId = '0;
        isMd   = 1'b0;
        case (op)
            ADDU: begin
                tuseRs = tCycles_t'(1);
                tuseRt = tCycles_t'(1);
                tnewId = tCycles_t'(2);
            end
            SLL: begin
                tuseRt = tCycles_t'(1);  // Shift amount is an immediate
                tnewId = tCycles_t'(2);
            end
            ORI: begin
                tuseRs = tCycles_t'(1);
                tnewId = tCycles_t'(2);
            end
            LUI:  tnewId = tCycles_t'(1);
            LW: begin
                tuseRs = tCycles_t'(1);
                tnewId = tCycles_t'(3);
            end
            LB: begin
                tuseRs = tCycles_t'(1);
                tnewId = tCycles_t'(5);  // Extra cycles for byte extract
            end
            SW: begin
                tuseRs = tCycles_t'(1);
                tuseRt = tCycles_t'(2);  // Store data needed in MEM
            end
            BEQ: begin
                tuseRs = '0;
                tuseRt = '0;
            end
            JR:   tuseRs = '0;
            JAL:  tnewId = tCycles_t'(1);
            MULT, DIV: begin
                tuseRs = tCycles_t'(1);
                tuseRt = tCycles_t'(1);
                isMd   = 1'b1;
            end
            MFLO: begin
                tnewId = tCycles_t'(2);
                isMd   = 1'b1;
            end
            MTLO: begin
                tuseRs = tCycles_t'(1);
                isMd   = 1'b1;
            end
            MFC0: tnewId = tCycles_t'(3);
            MTC0: tuseRt = tCycles_t'(2);
            default: ;  // NOP, ERET, ILLEGAL read and write nothing
        endcase
    end

endmodule

/* source/stageTracker.sv */
// EX and MEM stage records with Tnew aging, stall bubbles, flush clearing and macro PC
module stageTracker import pipePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  stageRec_t idRec,
    input  tCycles_t  tnewId,
    input  logic      stall,
    input  kCtrl_t    kCtrl,
    output stageRec_t exRec,
    output stageRec_t memRec,
    output pcVal_t    macroPc,
    output logic      macroBd
);

    logic flush;

    // One cycle closer to the result, never below zero
    function automatic tCycles_t ageTnew(tCycles_t t);
        return (t == '0) ? '0 : t - tCycles_t'(1);
    endfunction

    assign flush = (kCtrl != KC_NONE);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exRec.valid  <= 1'b0;
            memRec.valid <= 1'b0;
        end else begin
            exRec       <= idRec;
            exRec.tnew  <= tnewId;
            exRec.valid <= idRec.valid && !stall;   // Bubble on stall

            memRec      <= exRec;
            memRec.tnew <= ageTnew(exRec.tnew);
        end
    end

    // Oldest valid instruction still able to take an exception
    always_comb begin
        if (memRec.valid) begin
            macroPc = memRec.pc;
            macroBd = memRec.bd;
        end else if (exRec.valid) begin
            macroPc = exRec.pc;
            macroBd = exRec.bd;
        end else if (idRec.valid) begin
            macroPc = idRec.pc;
            macroBd = idRec.bd;
        end else begin
            macroPc = '0;
            macroBd = 1'b0;
        end
    end

endmodule

/* source/hazardDetect.sv */
// Read-after-write and multiply/divide busy stall decision for the ID instruction
module hazardDetect import pipePkg::*; (
    input  stageRec_t idRec,
    input  stageRec_t exRec,
    input  stageRec_t memRec,
    input  tCycles_t  tuseRs,
    input  tCycles_t  tuseRt,
    input  logic      isMd,
    input  logic      mdBusy,
    input  logic      flush,
    output logic      stall
);

    logic rsHit, rtHit, mdHit;

    // Result not ready by the time the source is read
    function automatic logic srcHit(regAddr_t src, tCycles_t tuse,
                                    stageRec_t ex, stageRec_t mem);
        return (src != '0) &&
               ((ex.valid && ex.dest == src && ex.tnew > tuse) ||
                (mem.valid && mem.dest == src && mem.tnew > tuse));
    endfunction

    assign rsHit = srcHit(idRec.rs, tuseRs, exRec, memRec);
    assign rtHit = srcHit(idRec.rt, tuseRt, exRec, memRec);
    assign mdHit = isMd && mdBusy;

    // Flush wins over any stall
    assign stall = idRec.valid && !flush && (rsHit || rtHit || mdHit);

endmodule

/* source/mdTimer.sv */
// Occupancy counter of the multiply/divide unit, started by MULT or DIV in EX
`include "pipe_defs.svh"

module mdTimer import pipePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  stageRec_t exRec,
    input  logic      flush,
    output logic      mdBusy
);

    logic [`MD_CNT_W-1:0] count;
    logic start;

    // A flushed MULT/DIV never reaches the unit
    assign start = exRec.valid && !flush && (exRec.op == MULT || exRec.op == DIV);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            if (exRec.op == DIV)
                count <= `MD_CNT_W'(`MD_DIV_CYCLES);
            else
                count <= `MD_CNT_W'(`MD_MULT_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mdBusy = (count != '0);

endmodule

/* source/excSequencer.sv */
// Kernel state machine issuing exception and ERET flushes, with the EPC register
module excSequencer import pipePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  stageRec_t memRec,
    input  logic      irq,
    input  pcVal_t    macroPc,
    output kCtrl_t    kCtrl,
    output pcVal_t    epc
);

    kState_t state;

    // Mealy outputs, same cycle as the cause in MEM
    always_comb begin
        kCtrl = KC_NONE;
        case (state)
            KS_USER:
                if (memRec.valid && (memRec.op == ILLEGAL || irq))
                    kCtrl = KC_KTEXT;
            KS_KERNEL:
                if (memRec.valid && memRec.op == ERET)  // irq masked here
                    kCtrl = KC_ERET;
            default: kCtrl = KC_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= KS_USER;
            epc   <= '0;
        end else begin
            case (kCtrl)
                KC_KTEXT: begin
                    epc   <= macroPc;   // Resume at the oldest victim
                    state <= KS_KERNEL;
                end
                KC_ERET: state <= KS_USER;
                default: ;
            endcase
        end
    end

endmodule

/* source/pipeCtrlTop.sv */
// Top of the hazard and exception control block, wiring timing decode, stages, stall and kernel FSM
module pipeCtrlTop import pipePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  stageRec_t instrId,
    input  logic      irq,
    output logic      stall,
    output kCtrl_t    kCtrl,
    output pcVal_t    epc,
    output pcVal_t    macroPc,
    output logic      macroBd
);

    tCycles_t tuseRs, tuseRt, tnewId;
    logic isMd;
    logic mdBusy;
    logic flush;
    stageRec_t exRec, memRec;

    assign flush = (kCtrl != KC_NONE);

    instrTiming timing0 (
        .op     (instrId.op),
        .tuseRs (tuseRs),
        .tuseRt (tuseRt),
        .tnewId (tnewId),
        .isMd   (isMd)
    );

    stageTracker tracker0 (
        .clk     (clk),
        .reset   (reset),
        .idRec   (instrId),
        .tnewId  (tnewId),
        .stall   (stall),
        .kCtrl   (kCtrl),
        .exRec   (exRec),
        .memRec  (memRec),
        .macroPc (macroPc),
        .macroBd (macroBd)
    );

    hazardDetect hazard0 (
        .idRec  (instrId),
        .exRec  (exRec),
        .memRec (memRec),
        .tuseRs (tuseRs),
        .tuseRt (tuseRt),
        .isMd   (isMd),
        .mdBusy (mdBusy),
        .flush  (flush),
        .stall  (stall)
    );

    mdTimer mdTimer0 (
        .clk    (clk),
        .reset  (reset),
        .exRec  (exRec),
        .flush  (flush),
        .mdBusy (mdBusy)
    );

    excSequencer excSeq0 (
        .clk     (clk),
        .reset   (reset),
        .memRec  (memRec),
        .irq     (irq),
        .macroPc (macroPc),
        .kCtrl   (kCtrl),
        .epc     (epc)
    );

endmodule

/* tests/pipeCtrl_assert.sv */
// Concurrent checks on stall and flush behavior, bound into the pipeline control top level
module pipeCtrlAssert import pipePkg::*; (
    input logic   clk,
    input logic   reset,
    input logic   stall,
    input kCtrl_t kCtrl,
    input logic   exValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // A flush always overrides the stall
    noStallDuringFlush: assert property (@(posedge clk) disable iff (reset)
        !(stall && kCtrl != KC_NONE))
        else $error("stall raised together with a flush command");

    bubbleAfterStallOrFlush: assert property (@(posedge clk) disable iff (reset)
        (stall || kCtrl != KC_NONE) |=> !exValid)
        else $error("EX still valid after a stall or a flush");

    // Kernel mode masks a second exception
    noBackToBackKtext: assert property (@(posedge clk) disable iff (reset)
        (kCtrl == KC_KTEXT) |=> (kCtrl != KC_KTEXT))
        else $error("exception flush issued in two consecutive cycles");

endmodule

bind pipeCtrlTop pipeCtrlAssert assert0 (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .kCtrl   (kCtrl),
    .exValid (exRec.valid)
);

/* tests/pipeCtrlTb.sv */
// Random instruction stream testbench for pipeCtrlTop, compared each cycle against a shadow model
`include "pipe_defs.svh"

module pipeCtrlTb import pipePkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INSTR = 600;
    localparam int WATCHDOG_NS = (NUM_INSTR * 12 + 50) * 40;  // Worst case stall per offer

    typedef struct packed {
        tCycles_t tuseRs;
        tCycles_t tuseRt;
        tCycles_t tnew;
        logic     isMd;
    } timing_t;

    logic clk, reset, irq, stall, macroBd;
    stageRec_t instrId;
    kCtrl_t kCtrl;
    pcVal_t epc, macroPc;

    stageRec_t mEx, mMem;           // Shadow stages
    int mdLeft;
    kState_t mState;
    pcVal_t mEpc, expPc, pc;
    timing_t tim;
    kCtrl_t expK;
    logic expStall, expBd, holdOffer, afterBranch;
    int offered, stallCount, mdStallCount, ktextCount, eretCount;

    pipeCtrlTop dut0 (.clk(clk), .reset(reset), .instrId(instrId), .irq(irq), .stall(stall),
                      .kCtrl(kCtrl), .epc(epc), .macroPc(macroPc), .macroBd(macroBd));

    // Tuse and Tnew per opcode, one column at a time
    function automatic timing_t refTiming(instrOp_t op);
        timing_t t;
        t.tuseRs = tCycles_t'(`TUSE_INF);
        t.tuseRt = tCycles_t'(`TUSE_INF);
        t.tnew = '0;
        case (op)
            ADDU, ORI, LW, LB, SW, MULT, DIV, MTLO: t.tuseRs = tCycles_t'(1);
            BEQ, JR: t.tuseRs = '0;
            default: ;
        endcase
        case (op)
            ADDU, SLL, MULT, DIV: t.tuseRt = tCycles_t'(1);
            SW, MTC0: t.tuseRt = tCycles_t'(2);
            BEQ: t.tuseRt = '0;
            default: ;
        endcase
        case (op)
            LUI, JAL: t.tnew = tCycles_t'(1);
            ADDU, SLL, ORI, MFLO: t.tnew = tCycles_t'(2);
            LW, MFC0: t.tnew = tCycles_t'(3);
            LB: t.tnew = tCycles_t'(5);
            default: ;
        endcase
        t.isMd = op inside {MULT, DIV, MFLO, MTLO};
        return t;
    endfunction

    function automatic logic srcBlocked(regAddr_t src, tCycles_t tuse);
        if (src == '0)
            return 1'b0;
        if (mEx.valid && mEx.dest == src && mEx.tnew > tuse)
            return 1'b1;
        return mMem.valid && mMem.dest == src && mMem.tnew > tuse;
    endfunction

    task automatic reportMismatch(string name, logic [31:0] expV, logic [31:0] actV);
        $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, name, expV, actV);
        $display("sim failed");
        $fatal(1, "output compare failed");
    endtask

    task automatic offerNext();
        stageRec_t rec;
        timing_t t;
        int r;
        r = $urandom_range(99);
        rec = '0;
        if (r < 2)
            rec.op = ILLEGAL;
        else if (r < 6)
            rec.op = ERET;
        else
            rec.op = instrOp_t'($urandom_range(16));   // NOP up to MTC0
        t = refTiming(rec.op);
        rec.valid = ($urandom_range(9) != 0);
        rec.rs = regAddr_t'($urandom_range(3));
        rec.rt = regAddr_t'($urandom_range(3));
        rec.dest = (t.tnew != '0) ? regAddr_t'($urandom_range(3)) : '0;
        rec.tnew = tCycles_t'($urandom);             // DUT must ignore it
        rec.pc = pc;
        rec.bd = afterBranch;
        if (rec.valid) begin
            pc = pc + 32'd4;
            afterBranch = rec.op inside {BEQ, JR, JAL};
        end
        instrId = rec;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d offers made", WATCHDOG_NS, offered);
        $display("sim failed");
        $fatal(1, "timeout");
    end

    // Reference model and compare, one step per rising edge
    always @(posedge clk) begin
        if (reset) begin
            mEx = '0;
            mMem = '0;
            mdLeft = 0;
            mState = KS_USER;
            mEpc = '0;
            holdOffer = 1'b0;
        end else begin
            tim = refTiming(instrId.op);
            expK = KC_NONE;
            if (mMem.valid && mState == KS_USER && (mMem.op == ILLEGAL || irq))
                expK = KC_KTEXT;
            if (mMem.valid && mState == KS_KERNEL && mMem.op == ERET)
                expK = KC_ERET;
            expStall = instrId.valid && expK == KC_NONE &&
                       (srcBlocked(instrId.rs, tim.tuseRs) || srcBlocked(instrId.rt, tim.tuseRt) ||
                        (tim.isMd && mdLeft != 0));
            expPc = mMem.valid ? mMem.pc : mEx.valid ? mEx.pc : instrId.valid ? instrId.pc : '0;
            expBd = mMem.valid ? mMem.bd : mEx.valid ? mEx.bd : instrId.valid && instrId.bd;

            assert (stall == expStall) else reportMismatch("stall", 32'(expStall), 32'(stall));
            assert (kCtrl == expK) else reportMismatch("kCtrl", 32'(expK), 32'(kCtrl));
            assert (epc == mEpc) else reportMismatch("epc", mEpc, epc);
            assert (macroPc == expPc) else reportMismatch("macroPc", expPc, macroPc);
            assert (macroBd == expBd) else reportMismatch("macroBd", 32'(expBd), 32'(macroBd));

            stallCount += int'(expStall);
            mdStallCount += int'(expStall && tim.isMd && mdLeft != 0);
            ktextCount += int'(expK == KC_KTEXT);
            eretCount += int'(expK == KC_ERET);

            if (expK != KC_NONE) begin
                mEx.valid = 1'b0;
                mMem.valid = 1'b0;
                if (mdLeft != 0)
                    mdLeft--;
                if (expK == KC_KTEXT)
                    mEpc = expPc;
                mState = (expK == KC_KTEXT) ? KS_KERNEL : KS_USER;
            end else begin
                if (mEx.valid && mEx.op inside {MULT, DIV})
                    mdLeft = (mEx.op == DIV) ? `MD_DIV_CYCLES : `MD_MULT_CYCLES;
                else if (mdLeft != 0)
                    mdLeft--;
                mMem = mEx;
                mMem.tnew = (mEx.tnew == '0) ? '0 : mEx.tnew - tCycles_t'(1);
                mEx = instrId;
                mEx.tnew = tim.tnew;
                mEx.valid = instrId.valid && !expStall;
            end
            holdOffer = expStall;   // Flushed offers are dropped too
        end
    end

    initial begin
        void'($urandom(32'h5f57_aba3));
        reset = 1'b1;
        irq = 1'b0;
        instrId = '0;
        pc = 32'h0000_3000;
        afterBranch = 1'b0;
        offered = 0;
        stallCount = 0;
        mdStallCount = 0;
        ktextCount = 0;
        eretCount = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        offerNext();
        offered = 1;
        while (offered < NUM_INSTR) begin
            @(negedge clk);
            if (!holdOffer) begin
                offerNext();
                offered++;
            end
            irq = ($urandom_range(99) < 2);
        end
        @(negedge clk);
        instrId.valid = 1'b0;
        irq = 1'b0;
        repeat (12) @(negedge clk);    // Drain stages and timer
        if (stallCount > 0 && mdStallCount > 0 && ktextCount > 0 && eretCount > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Stream missed a case: stalls %0d, md stalls %0d, KTEXT %0d, ERET %0d",
                     stallCount, mdStallCount, ktextCount, eretCount);
            $display("sim failed");
            $fatal(1, "coverage incomplete");
        end
    end

endmodule

/* flist.f */
+incdir+source
source/pipePkg.sv
source/instrTiming.sv
source/stageTracker.sv
source/hazardDetect.sv
source/mdTimer.sv
source/excSequencer.sv
source/pipeCtrlTop.sv
tests/pipeCtrl_assert.sv
tests/pipeCtrlTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipeCtrlTb -f flist.f -o simPipeCtrl &&
./obj_dir/simPipeCtrl || exit 1
